//--- renkon_pkg.sv
package renkon_pkg;

  localparam int DWIDTH       = 16;
  localparam int FWIDTH       = 8;  // Q8.8.
  localparam int PWIDTH       = 2 * DWIDTH;
  localparam int IMG_WIDTH    = 8;
  localparam int IMG_HEIGHT   = 8;
  localparam int KSIZE        = 3;
  localparam int KTAPS        = KSIZE * KSIZE;
  localparam int FMAP_WIDTH   = IMG_WIDTH - (KSIZE - 1);
  localparam int FMAP_HEIGHT  = IMG_HEIGHT - (KSIZE - 1);
  localparam int BIAS_ADDR    = 9;
  localparam int WADDR_WIDTH  = 4;
  localparam int COL_WIDTH    = $clog2(IMG_WIDTH);
  localparam int ROW_WIDTH    = $clog2(IMG_HEIGHT);
  localparam int TREE_LATENCY = 4;  // Input, product, rounding, sum.

  typedef logic signed [DWIDTH-1:0] data_t;

  localparam data_t DATA_MAX = {1'b0, {(DWIDTH-1){1'b1}}};
  localparam data_t DATA_MIN = {1'b1, {(DWIDTH-1){1'b0}}};

  // Tap 0 is the top-left pixel, taps follow raster order.
  typedef struct packed {
    data_t [KTAPS-1:0] tap;
  } window_t;

  typedef struct packed {
    data_t [KTAPS-1:0] weight;
    data_t             bias;
  } kernel_t;

  // Saturating sum of two Q8.8 words.
  function automatic data_t sat_add(input data_t a, input data_t b);
    logic signed [DWIDTH:0] s;
    s = a + b;
    if (s > DATA_MAX) begin
      return DATA_MAX;
    end else if (s < DATA_MIN) begin
      return DATA_MIN;
    end
    return data_t'(s);
  endfunction

  // Q16.16 product back to Q8.8, floor then saturate.
  function automatic data_t round_prod(input logic signed [PWIDTH-1:0] p);
    logic signed [PWIDTH-1:0] q;
    q = p >>> FWIDTH;
    if (q > DATA_MAX) begin
      return DATA_MAX;
    end else if (q < DATA_MIN) begin
      return DATA_MIN;
    end
    return data_t'(q);
  endfunction

endpackage

//--- renkon_weight_bank.sv
`timescale 1ns/1ps

module renkon_weight_bank (
  input  logic                               clk,
  input  logic                               xrst,
  input  logic                               weight_we,
  input  logic [renkon_pkg::WADDR_WIDTH-1:0] weight_addr,
  input  renkon_pkg::data_t                  weight_data,
  output renkon_pkg::kernel_t                kernel
);

  import renkon_pkg::*;

  kernel_t r_kernel;

  // Addresses 0..8 are weights in raster order, 9 is the bias.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_kernel <= '0;
    end else if (weight_we) begin
      for (int i = 0; i < KTAPS; i++) begin
        if (weight_addr == WADDR_WIDTH'(i)) begin
          r_kernel.weight[i] <= weight_data;
        end
      end
      if (weight_addr == WADDR_WIDTH'(BIAS_ADDR)) begin
        r_kernel.bias <= weight_data;
      end
    end
  end

  assign kernel = r_kernel;

endmodule

//--- renkon_window.sv
`timescale 1ns/1ps

module renkon_window (
  input  logic                clk,
  input  logic                xrst,
  input  logic                frame_start,
  input  logic                pixel_en,
  input  renkon_pkg::data_t   pixel,
  output renkon_pkg::window_t window,
  output logic                win_valid
);

  import renkon_pkg::*;

  data_t line1 [IMG_WIDTH];  // Previous row.
  data_t line2 [IMG_WIDTH];  // Two rows back.

  logic [COL_WIDTH-1:0] col;
  logic [ROW_WIDTH-1:0] row;
  logic                 last_col;
  logic                 last_row;
  logic                 completes;

  data_t [KSIZE-1:0] column_in;  // Incoming right column, top first.
  window_t           r_window;
  logic              r_win_valid;

  assign column_in[0] = line2[col];
  assign column_in[1] = line1[col];
  assign column_in[2] = pixel;

  assign last_col  = (col == COL_WIDTH'(IMG_WIDTH - 1));
  assign last_row  = (row == ROW_WIDTH'(IMG_HEIGHT - 1));
  assign completes = (row >= KSIZE - 1) && (col >= KSIZE - 1);

  // Each column slot moves one row older as the new pixel lands.
  always_ff @(posedge clk) begin
    if (pixel_en) begin
      line1[col] <= pixel;
      line2[col] <= line1[col];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      col <= '0;
      row <= '0;
    end else if (frame_start) begin
      col <= '0;
      row <= '0;
    end else if (pixel_en) begin
      if (last_col) begin
        col <= '0;
        if (last_row) begin
          row <= '0;
        end else begin
          row <= row + 1'b1;
        end
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // Shift left, new column enters on the right.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_window <= '0;
    end else if (pixel_en) begin
      for (int r = 0; r < KSIZE; r++) begin
        for (int c = 0; c < KSIZE - 1; c++) begin
          r_window.tap[r*KSIZE+c] <= r_window.tap[r*KSIZE+c+1];
        end
        r_window.tap[r*KSIZE+KSIZE-1] <= column_in[r];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_win_valid <= 1'b0;
    end else begin
      r_win_valid <= pixel_en && completes;  // Counters still point at this pixel.
    end
  end

  assign window    = r_window;
  assign win_valid = r_win_valid;

endmodule

//--- conv_tree9.sv
`timescale 1ns/1ps

module conv_tree9 (
  input  logic                clk,
  input  logic                xrst,
  input  renkon_pkg::window_t window,
  input  logic                win_valid,
  input  renkon_pkg::kernel_t kernel,
  output renkon_pkg::data_t   sum,
  output logic                sum_valid
);

  import renkon_pkg::*;

  window_t                  r_window;
  data_t [KTAPS-1:0]        r_weight;
  logic signed [PWIDTH-1:0] r_pro       [KTAPS];
  data_t                    r_pro_short [KTAPS];
  data_t                    r_sum;
  logic [TREE_LATENCY-1:0]  r_valid;

  data_t sum0 [4];
  data_t sum1 [2];
  data_t sum2;
  data_t sum3;

  // Stage 1. Input registers.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_window <= '0;
      r_weight <= '0;
    end else begin
      r_window <= window;
      r_weight <= kernel.weight;
    end
  end

  // Stage 2 and 3. Full products, then back to Q8.8.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < KTAPS; i++) begin
        r_pro[i]       <= '0;
        r_pro_short[i] <= '0;
      end
    end else begin
      for (int i = 0; i < KTAPS; i++) begin
        r_pro[i]       <= r_window.tap[i] * r_weight[i];
        r_pro_short[i] <= round_prod(r_pro[i]);
      end
    end
  end

  // Pairs first, tap 8 joins last. Each adder saturates.
  for (genvar i = 0; i < 4; i++) begin : g_level0
    assign sum0[i] = sat_add(r_pro_short[2*i], r_pro_short[2*i+1]);
  end

  assign sum1[0] = sat_add(sum0[0], sum0[1]);
  assign sum1[1] = sat_add(sum0[2], sum0[3]);
  assign sum2    = sat_add(sum1[0], sum1[1]);
  assign sum3    = sat_add(sum2, r_pro_short[8]);

  // Stage 4. Tree sum.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_sum <= '0;
    end else begin
      r_sum <= sum3;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_valid <= '0;
    end else begin
      r_valid <= {r_valid[TREE_LATENCY-2:0], win_valid};
    end
  end

  assign sum       = r_sum;
  assign sum_valid = r_valid[TREE_LATENCY-1];

endmodule

//--- renkon_bias_relu.sv
`timescale 1ns/1ps

module renkon_bias_relu (
  input  logic                clk,
  input  logic                xrst,
  input  renkon_pkg::data_t   sum,
  input  logic                sum_valid,
  input  renkon_pkg::kernel_t kernel,
  output renkon_pkg::data_t   fmap,
  output logic                fmap_valid
);

  import renkon_pkg::*;

  data_t biased;
  data_t relu;
  data_t r_fmap;
  logic  r_fmap_valid;

  assign biased = sat_add(sum, kernel.bias);
  assign relu   = biased[DWIDTH-1] ? '0 : biased;  // Negative clamps to zero.

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_fmap       <= '0;
      r_fmap_valid <= 1'b0;
    end else begin
      r_fmap_valid <= sum_valid;
      if (sum_valid) begin
        r_fmap <= relu;  // Holds the last value between outputs.
      end
    end
  end

  assign fmap       = r_fmap;
  assign fmap_valid = r_fmap_valid;

endmodule

//--- renkon_conv_core.sv
`timescale 1ns/1ps

module renkon_conv_core (
  input  logic                               clk,
  input  logic                               xrst,
  input  logic                               frame_start,
  input  logic                               pixel_en,
  input  renkon_pkg::data_t                  pixel,
  input  logic                               weight_we,
  input  logic [renkon_pkg::WADDR_WIDTH-1:0] weight_addr,
  input  renkon_pkg::data_t                  weight_data,
  output logic                               fmap_valid,
  output renkon_pkg::data_t                  fmap
);

  import renkon_pkg::*;

  kernel_t kernel;
  window_t window;
  logic    win_valid;
  data_t   sum;
  logic    sum_valid;

  renkon_weight_bank u_weight_bank (
    .clk         (clk),
    .xrst        (xrst),
    .weight_we   (weight_we),
    .weight_addr (weight_addr),
    .weight_data (weight_data),
    .kernel      (kernel)
  );

  // One cycle from pixel to window.
  renkon_window u_window (
    .clk         (clk),
    .xrst        (xrst),
    .frame_start (frame_start),
    .pixel_en    (pixel_en),
    .pixel       (pixel),
    .window      (window),
    .win_valid   (win_valid)
  );

  // Four cycles.
  conv_tree9 u_conv_tree9 (
    .clk       (clk),
    .xrst      (xrst),
    .window    (window),
    .win_valid (win_valid),
    .kernel    (kernel),
    .sum       (sum),
    .sum_valid (sum_valid)
  );

  // One cycle.
  renkon_bias_relu u_bias_relu (
    .clk        (clk),
    .xrst       (xrst),
    .sum        (sum),
    .sum_valid  (sum_valid),
    .kernel     (kernel),
    .fmap       (fmap),
    .fmap_valid (fmap_valid)
  );

endmodule

//--- renkon_conv_assert.sv
`timescale 1ns/1ps

module renkon_conv_assert (
  input logic              clk,
  input logic              xrst,
  input logic              fmap_valid,
  input renkon_pkg::data_t fmap
);

  import renkon_pkg::*;

  int fail_count = 0;

  a_quiet_in_reset: assert property (@(posedge clk) !xrst |=> !fmap_valid)
    else begin
      $error("fmap_valid high while reset is held");
      fail_count++;
    end

  // ReLU output.
  a_non_negative: assert property (
    @(posedge clk) disable iff (!xrst) fmap_valid |-> !fmap[DWIDTH-1])
    else begin
      $error("Negative fmap value %h", fmap);
      fail_count++;
    end

  // Window plus tree plus bias stage, six edges before the first output.
  a_fill_time: assert property (
    @(posedge clk) $rose(xrst) |-> !fmap_valid [*6])
    else begin
      $error("fmap_valid rose too soon after reset release");
      fail_count++;
    end

endmodule

bind renkon_conv_core renkon_conv_assert u_conv_assert (
  .clk        (clk),
  .xrst       (xrst),
  .fmap_valid (fmap_valid),
  .fmap       (fmap)
);

//--- tb_renkon_conv_core.sv
`timescale 1ns/1ps

module tb_renkon_conv_core;

  import renkon_pkg::*;

  localparam int NUM_IMAGES   = 4;
  localparam int NUM_PIXELS   = IMG_WIDTH * IMG_HEIGHT;
  localparam int NUM_OUTPUTS  = FMAP_WIDTH * FMAP_HEIGHT;
  localparam int IMAGE_WORDS  = KTAPS + 1 + NUM_PIXELS + NUM_OUTPUTS;
  localparam int OUT_EDGE     = 5;    // Output is seen after edge N+5.
  localparam int DRAIN_LIMIT  = 100;  // Cycles.
  localparam int STRAY_PIXELS = 5;

  typedef struct packed {
    data_t       value;
    logic [31:0] edge_no;  // Edge that sampled the completing pixel.
  } expect_t;

  logic                   clk;
  logic                   xrst;
  logic                   frame_start;
  logic                   pixel_en;
  data_t                  pixel;
  logic                   weight_we;
  logic [WADDR_WIDTH-1:0] weight_addr;
  data_t                  weight_data;
  logic                   fmap_valid;
  data_t                  fmap;

  data_t       testdata [NUM_IMAGES*IMAGE_WORDS];
  expect_t     expected_q [$];
  expect_t     head;
  logic [31:0] cycle;
  integer      seed;
  int          value_errors;
  int          latency_errors;
  int          other_errors;
  bit          abort;

  renkon_conv_core dut (
    .clk         (clk),
    .xrst        (xrst),
    .frame_start (frame_start),
    .pixel_en    (pixel_en),
    .pixel       (pixel),
    .weight_we   (weight_we),
    .weight_addr (weight_addr),
    .weight_data (weight_data),
    .fmap_valid  (fmap_valid),
    .fmap        (fmap)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;  // Equals N after edge N.
  end

  // Every output must match the next expected value and its edge.
  always @(negedge clk) begin
    if (fmap_valid) begin
      if (expected_q.size() == 0) begin
        $display("%0t: fmap_valid went high with no output expected", $time);
        other_errors++;
      end else begin
        head = expected_q.pop_front();
        if (fmap !== head.value) begin
          $display("CHECK FAILED at %0t: fmap %h, expected %h", $time, fmap, head.value);
          value_errors++;
        end
        if (cycle != head.edge_no + OUT_EDGE) begin
          $display("CHECK FAILED at %0t: output after edge %0d, expected after edge %0d",
                   $time, cycle, head.edge_no + OUT_EDGE);
          latency_errors++;
        end
      end
    end
  end

  task automatic load_kernel(input int base);
    for (int i = 0; i <= BIAS_ADDR; i++) begin
      @(negedge clk);
      weight_we   = 1'b1;
      weight_addr = WADDR_WIDTH'(i);
      weight_data = testdata[base + i];
    end
    @(negedge clk);
    weight_we = 1'b0;
  endtask

  // Pixels outside any frame, to be discarded by the next frame_start.
  task automatic send_stray(input int count);
    for (int i = 0; i < count; i++) begin
      @(negedge clk);
      pixel_en = 1'b1;
      pixel    = DATA_MAX;
    end
    @(negedge clk);
    pixel_en = 1'b0;
  endtask

  task automatic stream_image(input int base, input bit use_gaps);
    int      gap;
    int      k;
    expect_t e;
    k = 0;
    @(negedge clk);
    frame_start = 1'b1;
    for (int p = 0; p < NUM_PIXELS; p++) begin
      gap = use_gaps ? ($random(seed) & 3) : 0;
      repeat (gap) begin
        @(negedge clk);
        frame_start = 1'b0;
        pixel_en    = 1'b0;
      end
      @(negedge clk);
      frame_start = 1'b0;
      pixel_en    = 1'b1;
      pixel       = testdata[base + KTAPS + 1 + p];
      if (p / IMG_WIDTH >= KSIZE - 1 && p % IMG_WIDTH >= KSIZE - 1) begin
        e.value   = testdata[base + KTAPS + 1 + NUM_PIXELS + k];
        e.edge_no = cycle + 1;
        expected_q.push_back(e);
        k++;
      end
    end
    @(negedge clk);
    pixel_en = 1'b0;
  endtask

  task automatic wait_outputs(input int img);
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (expected_q.size() != 0) begin
      $display("Timeout at %0t: %0d outputs of image %0d did not arrive",
               $time, expected_q.size(), img);
      other_errors++;
      abort = 1'b1;
    end
  endtask

  initial begin
    seed           = 32'h5699_3a4a;
    cycle          = '0;
    value_errors   = 0;
    latency_errors = 0;
    other_errors   = 0;
    abort          = 1'b0;
    xrst           = 1'b0;
    frame_start    = 1'b0;
    pixel_en       = 1'b0;
    pixel          = '0;
    weight_we      = 1'b0;
    weight_addr    = '0;
    weight_data    = '0;
    $readmemh("renkon_testdata.txt", testdata);
    if ($isunknown(testdata[NUM_IMAGES*IMAGE_WORDS-1])) begin
      $display("Test data file is missing or holds fewer than %0d words",
               NUM_IMAGES * IMAGE_WORDS);
      other_errors++;
      abort = 1'b1;
    end
    repeat (16) @(negedge clk);
    xrst = 1'b1;
    // Image 0 runs without gaps, the others with random gaps.
    for (int img = 0; img < NUM_IMAGES && !abort; img++) begin
      if (img != 0) begin  // Image 0 runs on the kernel cleared by reset.
        load_kernel(img * IMAGE_WORDS);
      end
      if (img == 2) begin
        send_stray(STRAY_PIXELS);
      end
      stream_image(img * IMAGE_WORDS, img != 0);
      wait_outputs(img);
    end
    repeat (20) @(negedge clk);  // Any late extra output shows up here.
    $display("Errors: %0d value, %0d latency, %0d other, %0d assertion",
             value_errors, latency_errors, other_errors, dut.u_conv_assert.fail_count);
    if (value_errors + latency_errors + other_errors + dut.u_conv_assert.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- renkon_testdata.txt
// Per image: weights w0..w8 and bias, 64 pixels in raster order, 36 expected outputs.
// Every word is a Q8.8 value in 16-bit hex.
// Image 0. Zero kernel.
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
FC00 FC10 FC20 FC30 FC40 FC50 FC60 FC70 FD00 FD10 FD20 FD30 FD40 FD50 FD60 FD70
FE00 FE10 FE20 FE30 FE40 FE50 FE60 FE70 FF00 FF10 FF20 FF30 FF40 FF50 FF60 FF70
0000 0010 0020 0030 0040 0050 0060 0070 0100 0110 0120 0130 0140 0150 0160 0170
0200 0210 0220 0230 0240 0250 0260 0270 0300 0310 0320 0330 0340 0350 0360 0370
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
// Image 1. Identity kernel, centers clamped at zero.
0000 0000 0000 0000 0100 0000 0000 0000 0000 0000
FC00 FC10 FC20 FC30 FC40 FC50 FC60 FC70 FD00 FD10 FD20 FD30 FD40 FD50 FD60 FD70
FE00 FE10 FE20 FE30 FE40 FE50 FE60 FE70 FF00 FF10 FF20 FF30 FF40 FF50 FF60 FF70
0000 0010 0020 0030 0040 0050 0060 0070 0100 0110 0120 0130 0140 0150 0160 0170
0200 0210 0220 0230 0240 0250 0260 0270 0300 0310 0320 0330 0340 0350 0360 0370
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0010 0020 0030 0040 0050 0060
0110 0120 0130 0140 0150 0160 0210 0220 0230 0240 0250 0260
// Image 2. Mixed signs and fractions, rows of constant pixels.
0080 0000 FF80 0040 0100 0040 FFC0 FFC0 FFC0 0100
0180 0180 0180 0180 0180 0180 0180 0180 FF40 FF40 FF40 FF40 FF40 FF40 FF40 FF40
0055 0055 0055 0055 0055 0055 0055 0055 0200 0200 0200 0200 0200 0200 0200 0200
FE7F FE7F FE7F FE7F FE7F FE7F FE7F FE7F 0033 0033 0033 0033 0033 0033 0033 0033
012C 012C 012C 012C 012C 012C 012C 012C FFFD FFFD FFFD FFFD FFFD FFFD FFFD FFFD
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
051F 051F 051F 051F 051F 051F 0000 0000 0000 0000 0000 0000
0069 0069 0069 0069 0069 0069 02C1 02C1 02C1 02C1 02C1 02C1
// Image 3. Tree and bias saturation.
0100 0100 0100 0100 0100 0100 0100 0100 0100 2000
2000 2000 2000 2000 2000 2000 2000 2000 2000 2000 2000 2000 2000 2000 2000 2000
2000 2000 2000 2000 2000 2000 2000 2000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 E000 E000 E000 E000 E000 E000 E000 E000
E000 E000 E000 E000 E000 E000 E000 E000 E000 E000 E000 E000 E000 E000 E000 E000
7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF
7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000

//--- files.f
renkon_pkg.sv
renkon_weight_bank.sv
renkon_window.sv
conv_tree9.sv
renkon_bias_relu.sv
renkon_conv_core.sv
renkon_conv_assert.sv
tb_renkon_conv_core.sv

//--- Bender.yml
package:
  name: renkon_conv_core

sources:
  - renkon_pkg.sv
  - renkon_weight_bank.sv
  - renkon_window.sv
  - conv_tree9.sv
  - renkon_bias_relu.sv
  - renkon_conv_core.sv
  - target: simulation
    files:
      - renkon_conv_assert.sv
      - tb_renkon_conv_core.sv
